// File: hw/niox_pkg.sv
// ************************************************
// shared widths, address map and region type
// imported by the fabric RTL and the testbench
// ************************************************
`default_nettype none

package niox_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int SEL_W = DATA_W / 8;

   localparam int ROM_WORDS = 256;
   localparam int ROM_AW = $clog2(ROM_WORDS);
   localparam int RAM_WORDS = 1024;
   localparam int RAM_AW = $clog2(RAM_WORDS);
   localparam string ROM_INIT_FILE = "hw/boot_rom.hex";

   // region bounds, each limit is the first byte past the region
   localparam logic [ADDR_W-1:0] ROM_BASE = 32'h0000_0000;
   localparam logic [ADDR_W-1:0] RAM_BASE = 32'h0001_0000;
   localparam logic [ADDR_W-1:0] EXT_BASE = 32'h0010_0000;
   localparam logic [ADDR_W-1:0] EXT_LIMIT = 32'h003C_0000;
   localparam logic [ADDR_W-1:0] IO_BASE = 32'h00F0_0000;
   localparam logic [ADDR_W-1:0] IO_LIMIT = 32'h0100_0000;

   localparam int EXT_ADDR_W = 22;

   // keyboard register: valid flag above the scan code
   localparam logic [ADDR_W-1:0] KB_REG_ADDR = 32'h00F0_0000;
   localparam int KB_W = 16;
   localparam int KB_VALID_BIT = 16;

   typedef enum logic [2:0] {REG_ROM, REG_RAM, REG_EXT, REG_IO, REG_NONE} region_t;

endpackage

`default_nettype wire

// File: hw/bus_decoder.sv
// ************************************************
// data address decode, ROM arbitration between
// fetch and data, read data and ack return mux
// ************************************************
`default_nettype none

module bus_decoder import niox_pkg::*;
(
   input  wire                clk,
   input  wire                reset,
   input  wire                wb_cyc_i,
   input  wire                wb_stb_i,
   input  wire                wb_we_i,
   input  wire [SEL_W-1:0]    wb_sel_i,
   input  wire [ADDR_W-1:0]   wb_adr_i,
   output logic               wb_ack_o,
   output logic [DATA_W-1:0]  wb_dat_o,
   input  wire                ifetch_req_i,
   input  wire [ADDR_W-1:0]   ifetch_addr_i,
   output logic [DATA_W-1:0]  ifetch_data_o,
   output logic               ifetch_valid_o,
   output logic [ROM_AW-1:0]  rom_addr_o,
   output logic               rom_en_o,
   input  wire [DATA_W-1:0]   rom_data_i,
   output logic               ram_en_o,
   output logic               ram_we_o,
   output logic [SEL_W-1:0]   ram_be_o,
   input  wire                ram_ack_i,
   input  wire [DATA_W-1:0]   ram_data_i,
   output logic               ext_stb_o,
   output logic               io_stb_o,
   input  wire                bridge_ack_i,
   input  wire [DATA_W-1:0]   bridge_data_i
);

   logic              stb_active;
   region_t           region;
   logic              data_rom_rd;
   logic              local_ack;
   logic              fetch_issue;
   logic              d_rom_pend;
   logic              f_pend;
   logic              d_ack_q;
   logic [DATA_W-1:0] d_dat_q;

   function automatic logic in_range(input logic [ADDR_W-1:0] addr,
                                     input logic [ADDR_W-1:0] lo,
                                     input logic [ADDR_W-1:0] hi);
      logic [ADDR_W-1:0] off;
      off = addr - lo;
      return off < (hi - lo);
   endfunction

   // ************************************************
   // region decode and slave strobes
   // ************************************************
   assign stb_active = wb_cyc_i && wb_stb_i;

   always_comb
   begin
      if (in_range(wb_adr_i, ROM_BASE, RAM_BASE))
         region = REG_ROM;
      else if (in_range(wb_adr_i, RAM_BASE, EXT_BASE))
         region = REG_RAM;
      else if (in_range(wb_adr_i, EXT_BASE, EXT_LIMIT))
         region = REG_EXT;
      else if (in_range(wb_adr_i, IO_BASE, IO_LIMIT))
         region = REG_IO;
      else
         region = REG_NONE;
   end

   assign ram_en_o = stb_active && (region == REG_RAM);
   assign ram_we_o = ram_en_o && wb_we_i;
   assign ram_be_o = wb_sel_i;
   assign ext_stb_o = stb_active && (region == REG_EXT);
   assign io_stb_o = stb_active && (region == REG_IO);

   // ************************************************
   // ROM port, data first
   // ************************************************
   // one ROM read per data access
   assign data_rom_rd = stb_active && (region == REG_ROM) && !wb_we_i
                        && !d_rom_pend && !d_ack_q;
   // holes and ROM writes are acked here and dropped
   assign local_ack = stb_active && !d_ack_q
                      && ((region == REG_NONE) || ((region == REG_ROM) && wb_we_i));
   assign fetch_issue = ifetch_req_i && !data_rom_rd && !f_pend && !ifetch_valid_o;

   assign rom_en_o = data_rom_rd || fetch_issue;
   assign rom_addr_o = data_rom_rd ? wb_adr_i[ROM_AW+1:2] : ifetch_addr_i[ROM_AW+1:2];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         d_rom_pend <= 1'b0;
         f_pend <= 1'b0;
         d_ack_q <= 1'b0;
         ifetch_valid_o <= 1'b0;
      end
      else
      begin
         d_rom_pend <= data_rom_rd;
         f_pend <= fetch_issue;
         d_ack_q <= local_ack || d_rom_pend;
         ifetch_valid_o <= f_pend;
      end
   end

   // rom_data_i belongs to whichever side issued last cycle
   always_ff @(posedge clk)
   begin
      d_dat_q <= d_rom_pend ? rom_data_i : '0;
      if (f_pend)
         ifetch_data_o <= rom_data_i;
   end

   // ************************************************
   // return path to the master
   // ************************************************
   assign wb_ack_o = d_ack_q || ram_ack_i || bridge_ack_i;

   always_comb
   begin
      case (region)
         REG_RAM: wb_dat_o = ram_data_i;
         REG_EXT, REG_IO: wb_dat_o = bridge_data_i;
         default: wb_dat_o = d_dat_q;
      endcase
   end

   // only one slave answers in any cycle
   a_one_slave: assert property (@(posedge clk) disable iff (reset)
      $onehot0({d_ack_q, ram_ack_i, bridge_ack_i}));

   // slave acks must only answer a live strobe
   a_ack_with_stb: assert property (@(posedge clk) disable iff (reset)
      wb_ack_o |-> wb_stb_i);

endmodule

`default_nettype wire

// File: hw/boot_rom.sv
// ************************************************
// boot ROM, one registered read per enabled cycle
// contents come from the hex image at elaboration
// ************************************************
`default_nettype none

module boot_rom import niox_pkg::*;
(
   input  wire                clk,
   input  wire                rom_en_i,
   input  wire [ROM_AW-1:0]   rom_addr_i,
   output logic [DATA_W-1:0]  rom_data_o
);

   logic [DATA_W-1:0] mem [ROM_WORDS];

   initial
   begin
      $readmemh(ROM_INIT_FILE, mem);
   end

   // address already wrapped to the ROM depth by the decoder
   always_ff @(posedge clk)
   begin
      if (rom_en_i)
         rom_data_o <= mem[rom_addr_i];
   end

endmodule

`default_nettype wire

// File: hw/data_ram.sv
// ************************************************
// on-chip data RAM with byte lane writes
// ack follows the strobe by one cycle
// ************************************************
`default_nettype none

module data_ram import niox_pkg::*;
(
   input  wire                clk,
   input  wire                reset,
   input  wire                ram_en_i,
   input  wire                ram_we_i,
   input  wire [SEL_W-1:0]    ram_be_i,
   input  wire [ADDR_W-1:0]   ram_addr_i,
   input  wire [DATA_W-1:0]   ram_data_i,
   output logic [DATA_W-1:0]  ram_data_o,
   output logic               ram_ack_o
);

   logic [DATA_W-1:0] mem [RAM_WORDS];
   logic [RAM_AW-1:0] idx;
   logic              access;

   // word index wraps modulo the depth
   assign idx = ram_addr_i[RAM_AW+1:2];
   // no second access while the strobe is still held over the ack
   assign access = ram_en_i && !ram_ack_o;

   always_ff @(posedge clk)
   begin
      if (reset)
         ram_ack_o <= 1'b0;
      else
         ram_ack_o <= access;
   end

   always_ff @(posedge clk)
   begin
      if (access)
      begin
         if (ram_we_i)
         begin
            for (int i = 0; i < SEL_W; i++)
            begin
               if (ram_be_i[i])
                  mem[idx][8*i +: 8] <= ram_data_i[8*i +: 8];
            end
         end
         ram_data_o <= mem[idx];
      end
   end

endmodule

`default_nettype wire

// File: hw/io_bridge.sv
// ************************************************
// external memory req/ready/done bridge and the
// keyboard register with its interrupt
// ************************************************
`default_nettype none

module io_bridge import niox_pkg::*;
(
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  ext_stb_i,
   input  wire                  io_stb_i,
   input  wire                  we_i,
   input  wire [ADDR_W-1:0]     addr_i,
   input  wire [DATA_W-1:0]     data_i,
   output logic                 bridge_ack_o,
   output logic [DATA_W-1:0]    bridge_data_o,
   output logic                 ext_req_o,
   output logic                 ext_write_o,
   output logic [EXT_ADDR_W-1:0] ext_addr_o,
   output logic [DATA_W-1:0]    ext_wdata_o,
   input  wire [DATA_W-1:0]     ext_rdata_i,
   input  wire                  ext_ready_i,
   input  wire                  ext_done_i,
   input  wire [KB_W-1:0]       kb_data_i,
   input  wire                  kb_ready_i,
   output logic                 irq_o
);

   typedef enum logic [1:0] {IDLE, REQ, WAIT, ACK} state_t;

   state_t            state;
   region_t           acc_region;
   logic [ADDR_W-1:0] ext_off;
   logic [DATA_W-1:0] ext_rdata_q;
   logic              io_ack_q;
   logic [DATA_W-1:0] io_word;
   logic [DATA_W-1:0] io_rdata_q;
   logic [KB_W-1:0]   kb_code;
   logic              kb_valid;
   logic              kb_hit;

   assign acc_region = ext_stb_i ? REG_EXT : (io_stb_i ? REG_IO : REG_NONE);
   assign ext_off = addr_i - EXT_BASE;

   // ************************************************
   // external memory handshake
   // ************************************************
   assign ext_req_o = (state == REQ);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= IDLE;
         ext_write_o <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE:
               if (acc_region == REG_EXT)
               begin
                  state <= REQ;
                  ext_write_o <= we_i;
               end
            REQ:
               if (ext_ready_i)
                  state <= WAIT;
            WAIT:
               if (ext_done_i)
                  state <= ACK;
            default:
            begin
               state <= IDLE;
               ext_write_o <= 1'b0;
            end
         endcase
      end
   end

   // address and data are in place before req rises
   always_ff @(posedge clk)
   begin
      if (state == IDLE)
      begin
         ext_addr_o <= ext_off[EXT_ADDR_W+1:2];
         ext_wdata_o <= data_i;
      end
      if ((state == WAIT) && ext_done_i)
         ext_rdata_q <= ext_rdata_i;
   end

   // ************************************************
   // keyboard register
   // ************************************************
   assign kb_hit = (addr_i == KB_REG_ADDR) && !we_i;

   always_comb
   begin
      io_word = '0;
      io_word[KB_W-1:0] = kb_code;
      io_word[KB_VALID_BIT] = kb_valid;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         io_ack_q <= 1'b0;
         kb_valid <= 1'b0;
         kb_code <= '0;
      end
      else
      begin
         io_ack_q <= (acc_region == REG_IO) && !io_ack_q;
         // a new code beats the read that clears the flag
         if (kb_ready_i)
         begin
            kb_valid <= 1'b1;
            kb_code <= kb_data_i;
         end
         else if (io_ack_q && kb_hit)
            kb_valid <= 1'b0;
      end
   end

   // other I/O addresses and writes read back zero
   always_ff @(posedge clk)
   begin
      io_rdata_q <= kb_hit ? io_word : '0;
   end

   assign bridge_ack_o = (state == ACK) || io_ack_q;
   assign bridge_data_o = io_ack_q ? io_rdata_q : ext_rdata_q;
   assign irq_o = kb_valid;

   // req and its fields hold through a stall
   a_req_hold: assert property (@(posedge clk) disable iff (reset)
      ext_req_o && !ext_ready_i |=> ext_req_o && $stable(ext_addr_o)
         && $stable(ext_wdata_o) && $stable(ext_write_o));

endmodule

`default_nettype wire

// File: hw/niox_sys.sv
// ************************************************
// memory and I/O fabric top, Wishbone data port and
// fetch port in, external memory and keyboard out
// ************************************************
`default_nettype none

module niox_sys import niox_pkg::*;
(
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   wb_cyc_i,
   input  wire                   wb_stb_i,
   input  wire                   wb_we_i,
   input  wire [SEL_W-1:0]       wb_sel_i,
   input  wire [ADDR_W-1:0]      wb_adr_i,
   input  wire [DATA_W-1:0]      wb_dat_i,
   output logic                  wb_ack_o,
   output logic [DATA_W-1:0]     wb_dat_o,
   input  wire                   ifetch_req_i,
   input  wire [ADDR_W-1:0]      ifetch_addr_i,
   output logic [DATA_W-1:0]     ifetch_data_o,
   output logic                  ifetch_valid_o,
   output logic                  ext_req_o,
   output logic                  ext_write_o,
   output logic [EXT_ADDR_W-1:0] ext_addr_o,
   output logic [DATA_W-1:0]     ext_wdata_o,
   input  wire [DATA_W-1:0]      ext_rdata_i,
   input  wire                   ext_ready_i,
   input  wire                   ext_done_i,
   input  wire [KB_W-1:0]        kb_data_i,
   input  wire                   kb_ready_i,
   output logic                  irq_o
);

   logic [ROM_AW-1:0] rom_addr;
   logic              rom_en;
   logic [DATA_W-1:0] rom_data;
   logic              ram_en;
   logic              ram_we;
   logic [SEL_W-1:0]  ram_be;
   logic              ram_ack;
   logic [DATA_W-1:0] ram_data;
   logic              ext_stb;
   logic              io_stb;
   logic              bridge_ack;
   logic [DATA_W-1:0] bridge_data;

   bus_decoder u_bus_decoder (
      .clk(clk), .reset(reset),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_sel_i(wb_sel_i), .wb_adr_i(wb_adr_i),
      .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
      .ifetch_req_i(ifetch_req_i), .ifetch_addr_i(ifetch_addr_i),
      .ifetch_data_o(ifetch_data_o), .ifetch_valid_o(ifetch_valid_o),
      .rom_addr_o(rom_addr), .rom_en_o(rom_en), .rom_data_i(rom_data),
      .ram_en_o(ram_en), .ram_we_o(ram_we), .ram_be_o(ram_be),
      .ram_ack_i(ram_ack), .ram_data_i(ram_data),
      .ext_stb_o(ext_stb), .io_stb_o(io_stb),
      .bridge_ack_i(bridge_ack), .bridge_data_i(bridge_data)
   );

   boot_rom u_boot_rom (
      .clk(clk), .rom_en_i(rom_en), .rom_addr_i(rom_addr), .rom_data_o(rom_data)
   );

   // address and write data go straight from the port
   data_ram u_data_ram (
      .clk(clk), .reset(reset),
      .ram_en_i(ram_en), .ram_we_i(ram_we), .ram_be_i(ram_be),
      .ram_addr_i(wb_adr_i), .ram_data_i(wb_dat_i),
      .ram_data_o(ram_data), .ram_ack_o(ram_ack)
   );

   io_bridge u_io_bridge (
      .clk(clk), .reset(reset),
      .ext_stb_i(ext_stb), .io_stb_i(io_stb), .we_i(wb_we_i),
      .addr_i(wb_adr_i), .data_i(wb_dat_i),
      .bridge_ack_o(bridge_ack), .bridge_data_o(bridge_data),
      .ext_req_o(ext_req_o), .ext_write_o(ext_write_o),
      .ext_addr_o(ext_addr_o), .ext_wdata_o(ext_wdata_o),
      .ext_rdata_i(ext_rdata_i), .ext_ready_i(ext_ready_i), .ext_done_i(ext_done_i),
      .kb_data_i(kb_data_i), .kb_ready_i(kb_ready_i), .irq_o(irq_o)
   );

endmodule

`default_nettype wire

// File: verification/niox_sys_tb.sv
// ************************************************
// testbench for the fabric that plays the processor on
// the Wishbone and fetch ports and models ext memory
// ************************************************
`default_nettype none

module niox_sys_tb import niox_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   logic clk, reset;
   logic wb_cyc_i, wb_stb_i, wb_we_i;
   logic [SEL_W-1:0] wb_sel_i;
   logic [ADDR_W-1:0] wb_adr_i;
   logic [DATA_W-1:0] wb_dat_i, wb_dat_o, ifetch_data_o, ext_wdata_o, ext_rdata_i;
   logic wb_ack_o, ifetch_req_i, ifetch_valid_o;
   logic [ADDR_W-1:0] ifetch_addr_i;
   logic ext_req_o, ext_write_o, ext_ready_i, ext_done_i, kb_ready_i, irq_o;
   logic [EXT_ADDR_W-1:0] ext_addr_o, last_ext_addr;
   logic [KB_W-1:0] kb_data_i;
   logic [DATA_W-1:0] rom_img [ROM_WORDS];
   logic [DATA_W-1:0] ext_mem [64];
   logic last_ext_write, ext_cycle, kb_cycle;
   integer seed = 32'h4fc1;
   int extra_hold;
   int cycles = 0;

   niox_sys u_niox_sys (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic stop_on_error(input string msg);
      $display("error at %0t ns: %s", $time, msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
      else
         stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic wb_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                            input logic [31:0] dat, output logic [31:0] rdata, output int lat);
      @(posedge clk);
      #2;
      {wb_cyc_i, wb_stb_i, wb_we_i, wb_sel_i, wb_adr_i, wb_dat_i} = {2'b11, we, sel, adr, dat};
      lat = 0;
      do
      begin
         @(negedge clk);
         lat++;
      end
      while (!wb_ack_o);
      rdata = wb_dat_o;
      @(posedge clk);
      #2;
      {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
   endtask

   task automatic fetch(input logic [31:0] adr, output logic [31:0] data, output int lat);
      @(posedge clk);
      #2;
      ifetch_req_i = 1'b1;
      ifetch_addr_i = adr;
      lat = 0;
      do
      begin
         @(negedge clk);
         lat++;
      end
      while (!ifetch_valid_o);
      data = ifetch_data_o;
      @(posedge clk);
      #2;
      ifetch_req_i = 1'b0;
   endtask

   // ************************************************
   // external memory model
   // ************************************************
   initial
   begin
      int hold;
      int gap;
      for (int i = 0; i < 64; i++)
         ext_mem[i] = 32'h5eed_0000 + i * 4;
      {ext_ready_i, ext_done_i, ext_rdata_i} = '0;
      forever
      begin
         @(negedge clk);
         if (ext_req_o && !reset)
         begin
            hold = ($unsigned($random(seed)) % 4) + extra_hold;
            repeat (hold) @(posedge clk);
            @(posedge clk);
            #2;
            ext_ready_i = 1'b1;
            last_ext_addr = ext_addr_o;
            last_ext_write = ext_write_o;
            if (ext_write_o)
               ext_mem[ext_addr_o[5:0]] = ext_wdata_o;
            @(posedge clk);
            #2;
            ext_ready_i = 1'b0;
            gap = 1 + ($unsigned($random(seed)) % 3);
            repeat (gap - 1)
            begin
               @(posedge clk);
               #2;
            end
            ext_done_i = 1'b1;
            ext_rdata_i = ext_mem[last_ext_addr[5:0]];
            @(posedge clk);
            #2;
            ext_done_i = 1'b0;
         end
      end
   end

   // ************************************************
   // protocol checks
   // ************************************************
   a_ack_needs_stb: assert property (@(posedge clk) disable iff (reset) wb_ack_o |-> wb_stb_i)
      else stop_on_error("ack seen without a strobe");
   a_ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack_o |=> !wb_ack_o)
      else stop_on_error("ack stayed high for more than one cycle");
   a_valid_single: assert property (@(posedge clk) disable iff (reset)
      ifetch_valid_o |=> !ifetch_valid_o)
      else stop_on_error("fetch valid stayed high for more than one cycle");
   a_ext_after_done: assert property (@(posedge clk) disable iff (reset)
      wb_ack_o && ext_cycle |-> $past(ext_done_i))
      else stop_on_error("external ack did not follow done by one cycle");
   a_kb_clear: assert property (@(posedge clk) disable iff (reset)
      wb_ack_o && kb_cycle && !kb_ready_i |=> !irq_o)
      else stop_on_error("irq still high after keyboard register read");

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles == 4000)
      begin
         $display("timeout: the tests did not finish within 4000 cycles");
         $display("TEST FAILED");
         $fatal(1);
      end
   end

   initial
   begin
      logic [31:0] d;
      logic [31:0] f;
      int lat;
      int flat;
      $readmemh(ROM_INIT_FILE, rom_img);
      {reset, wb_cyc_i, wb_stb_i, wb_we_i, ifetch_req_i, kb_ready_i} = 6'b100000;
      {wb_sel_i, wb_adr_i, wb_dat_i, ifetch_addr_i, kb_data_i} = '0;
      {ext_cycle, kb_cycle, extra_hold} = '0;
      repeat (5) @(posedge clk);
      #2;
      reset = 1'b0;
      @(negedge clk);
      check_word("idle outputs",
                 32'({wb_ack_o, ifetch_valid_o, ext_req_o, ext_write_o, irq_o}), 0);

      // ROM reads alone and shared with a fetch
      wb_access(0, 32'h0000_0408, 4'hf, 0, d, lat);
      check_word("rom read", d, rom_img[2]);
      check_word("rom read latency", lat, 3);
      fetch(32'h0000_fffc, f, flat);
      check_word("fetch", f, rom_img[255]);
      fork
         wb_access(0, 32'h0000_0020, 4'hf, 0, d, lat);
         fetch(32'h0000_0104, f, flat);
      join
      check_word("shared rom read", d, rom_img[8]);
      check_word("shared fetch", f, rom_img[65]);
      check_word("fetch waits for data", 32'(flat > lat), 1);

      // RAM byte lanes and aliasing
      wb_access(1, RAM_BASE + 32'h40, 4'hf, 32'h1122_3344, d, lat);
      wb_access(1, RAM_BASE + 32'h40, 4'b0101, 32'haabb_ccdd, d, lat);
      wb_access(0, RAM_BASE + 32'h40, 4'hf, 0, d, lat);
      check_word("ram byte lanes", d, 32'h11bb_33dd);
      check_word("ram latency", lat, 2);
      wb_access(0, RAM_BASE + 32'h40 + RAM_WORDS * 4, 4'hf, 0, d, lat);
      check_word("ram alias", d, 32'h11bb_33dd);

      // external memory with normal and stalled ready
      ext_cycle = 1'b1;
      wb_access(1, EXT_BASE + 32'h20, 4'hf, 32'hcafe_f00d, d, lat);
      check_word("ext write address", 32'(last_ext_addr), 8);
      check_word("ext write flag", 32'(last_ext_write), 1);
      check_word("ext write data", ext_mem[8], 32'hcafe_f00d);
      wb_access(0, EXT_BASE + 32'h20, 4'hf, 0, d, lat);
      check_word("ext read back", d, 32'hcafe_f00d);
      check_word("ext read flag", 32'(last_ext_write), 0);
      extra_hold = 6;
      wb_access(0, EXT_BASE + 32'h44, 4'hf, 0, d, lat);
      check_word("ext read stalled", d, 32'h5eed_0044);
      check_word("ext read address", 32'(last_ext_addr), 17);
      extra_hold = 0;
      ext_cycle = 1'b0;

      // keyboard register
      @(posedge clk);
      #2;
      {kb_ready_i, kb_data_i} = {1'b1, 16'h1c5a};
      @(posedge clk);
      #2;
      kb_ready_i = 1'b0;
      @(negedge clk);
      check_word("irq after key", 32'(irq_o), 1);
      kb_cycle = 1'b1;
      wb_access(0, KB_REG_ADDR, 4'hf, 0, d, lat);
      check_word("kb read", d, 32'h0001_1c5a);
      check_word("kb latency", lat, 2);
      @(negedge clk);
      check_word("irq after read", 32'(irq_o), 0);
      wb_access(0, KB_REG_ADDR, 4'hf, 0, d, lat);
      check_word("kb second read", d, 32'h0000_1c5a);
      kb_cycle = 1'b0;
      wb_access(0, IO_BASE + 32'h10, 4'hf, 0, d, lat);
      check_word("other io read", d, 0);

      // unmapped access and ROM writes
      wb_access(0, 32'h0080_0000, 4'hf, 0, d, lat);
      check_word("unmapped read", d, 0);
      check_word("unmapped latency", lat, 2);
      wb_access(1, 32'h0000_0408, 4'hf, 32'hdead_beef, d, lat);
      check_word("rom write latency", lat, 2);
      wb_access(0, 32'h0000_0408, 4'hf, 0, d, lat);
      check_word("rom after write", d, rom_img[2]);

      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/boot_rom.hex
// boot ROM image, 16 words per line, word address rising left to right
00ff 01fe 02fd 03fc 04fb 05fa 06f9 07f8 08f7 09f6 0af5 0bf4 0cf3 0df2 0ef1 0ff0
10ef 11ee 12ed 13ec 14eb 15ea 16e9 17e8 18e7 19e6 1ae5 1be4 1ce3 1de2 1ee1 1fe0
20df 21de 22dd 23dc 24db 25da 26d9 27d8 28d7 29d6 2ad5 2bd4 2cd3 2dd2 2ed1 2fd0
30cf 31ce 32cd 33cc 34cb 35ca 36c9 37c8 38c7 39c6 3ac5 3bc4 3cc3 3dc2 3ec1 3fc0
40bf 41be 42bd 43bc 44bb 45ba 46b9 47b8 48b7 49b6 4ab5 4bb4 4cb3 4db2 4eb1 4fb0
50af 51ae 52ad 53ac 54ab 55aa 56a9 57a8 58a7 59a6 5aa5 5ba4 5ca3 5da2 5ea1 5fa0
609f 619e 629d 639c 649b 659a 6699 6798 6897 6996 6a95 6b94 6c93 6d92 6e91 6f90
708f 718e 728d 738c 748b 758a 7689 7788 7887 7986 7a85 7b84 7c83 7d82 7e81 7f80
807f 817e 827d 837c 847b 857a 8679 8778 8877 8976 8a75 8b74 8c73 8d72 8e71 8f70
906f 916e 926d 936c 946b 956a 9669 9768 9867 9966 9a65 9b64 9c63 9d62 9e61 9f60
a05f a15e a25d a35c a45b a55a a659 a758 a857 a956 aa55 ab54 ac53 ad52 ae51 af50
b04f b14e b24d b34c b44b b54a b649 b748 b847 b946 ba45 bb44 bc43 bd42 be41 bf40
c03f c13e c23d c33c c43b c53a c639 c738 c837 c936 ca35 cb34 cc33 cd32 ce31 cf30
d02f d12e d22d d32c d42b d52a d629 d728 d827 d926 da25 db24 dc23 dd22 de21 df20
e01f e11e e21d e31c e41b e51a e619 e718 e817 e916 ea15 eb14 ec13 ed12 ee11 ef10
f00f f10e f20d f30c f40b f50a f609 f708 f807 f906 fa05 fb04 fc03 fd02 fe01 ff00

// File: project.f
hw/niox_pkg.sv
hw/bus_decoder.sv
hw/boot_rom.sv
hw/data_ram.sv
hw/io_bridge.sv
hw/niox_sys.sv
verification/niox_sys_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module niox_sys_tb -o niox_sim
	out=$$(./obj_dir/niox_sim); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
